/* dv/radar_capture_tb.sv */
`timescale 1ns/1ps

module radar_capture_tb;
  import chirp_pkg::*;

  // all tests together take well under 500 cycles
  localparam int MAX_CYCLES = 4000;

  logic        clk_245_76MHz;
  logic        cpu_reset;
  logic        chirp_init_i;
  logic        chirp_enable_i;
  logic        adc_enable_i;
  logic [31:0] chirp_control_word_i;
  logic [31:0] chirp_freq_offset_i;
  logic [31:0] chirp_tuning_word_coeff_i;
  logic [31:0] chirp_count_max_i;
  logic        capture_ready_i;
  logic        chirp_ready_o;
  logic        chirp_active_o;
  logic        chirp_done_o;
  logic [63:0] capture_data_o;
  logic        capture_valid_o;
  logic        capture_first_o;
  logic        capture_last_o;
  logic        capture_overflow_o;

  // errors from check tasks, frame monitor and properties
  int errors = 0;
  int frame_errors = 0;
  int prop_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_cnt = 0;
  int frame_cnt = 0;
  logic in_frame = 1'b0;
  // randomize capture_ready_i on every cycle while set
  logic random_ready;
  // frame being collected, and the last complete frame
  capture_word_t cur_q[$];
  capture_word_t frame_q[$];

  radar_capture_top radar_capture_top_i (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset(cpu_reset),
    .chirp_init_i(chirp_init_i),
    .chirp_enable_i(chirp_enable_i),
    .adc_enable_i(adc_enable_i),
    .chirp_control_word_i(chirp_control_word_i),
    .chirp_freq_offset_i(chirp_freq_offset_i),
    .chirp_tuning_word_coeff_i(chirp_tuning_word_coeff_i),
    .chirp_count_max_i(chirp_count_max_i),
    .capture_ready_i(capture_ready_i),
    .chirp_ready_o(chirp_ready_o),
    .chirp_active_o(chirp_active_o),
    .chirp_done_o(chirp_done_o),
    .capture_data_o(capture_data_o),
    .capture_valid_o(capture_valid_o),
    .capture_first_o(capture_first_o),
    .capture_last_o(capture_last_o),
    .capture_overflow_o(capture_overflow_o)
  );

  // 4 ns period
  initial begin
    clk_245_76MHz = 1'b0;
    forever begin
      #2 clk_245_76MHz = ~clk_245_76MHz;
    end
  end

  always @(posedge clk_245_76MHz) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a chirp or frame never completed", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // mid-cycle sample, a word moves on the next edge when valid and ready
  always @(negedge clk_245_76MHz) begin
    if (!cpu_reset && capture_valid_o && capture_ready_i) begin
      if (capture_first_o) begin
        assert (!in_frame) else begin
          $display("header arrived before the trailer of the previous frame");
          frame_errors++;
        end
        in_frame = 1'b1;
        cur_q.delete();
      end
      assert (in_frame) else begin
        $display("word arrived outside a frame");
        frame_errors++;
      end
      cur_q.push_back(capture_data_o);
      if (capture_last_o) begin
        in_frame = 1'b0;
        frame_q = cur_q;
        frame_cnt++;
      end
    end
  end

  a_done_after_active: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    $fell(chirp_active_o) |-> chirp_done_o) else begin
    $display("chirp_done_o missing on the cycle after the last active cycle");
    prop_errors++;
  end

  a_done_single: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    chirp_done_o |=> !chirp_done_o) else begin
    $display("chirp_done_o stayed high for more than one cycle");
    prop_errors++;
  end

  a_output_hold: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    capture_valid_o && !capture_ready_i |=> capture_valid_o && $stable(capture_data_o)
      && $stable(capture_first_o) && $stable(capture_last_o)) else begin
    $display("output word changed while stalled");
    prop_errors++;
  end

  a_first_not_last: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    capture_valid_o |-> !(capture_first_o && capture_last_o)) else begin
    $display("header and trailer flags set on the same word");
    prop_errors++;
  end

  function automatic int total_errors();
    return errors + frame_errors + prop_errors;
  endfunction

  // arithmetic shift right by one
  function automatic logic [15:0] halve_signed(input logic [15:0] x);
    return 16'($signed(x) >>> 1);
  endfunction

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_245_76MHz);
    #1;
    if (random_ready) begin
      capture_ready_i = ($urandom_range(9, 0) < 7);
    end
  endtask

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] want);
    assert (got === want) else begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  task automatic wait_frames(input int target);
    while (frame_cnt < target) begin
      next_cycle();
    end
  endtask

  // first/last already checked by the monitor
  task automatic check_frame(input int en_cycles);
    int len;
    int data_cnt;
    len = frame_q.size();
    data_cnt = len - 2;
    expect_true(len % FRAME_ALIGN_WORDS == 0,
                $sformatf("frame length %0d is not a multiple of %0d", len, FRAME_ALIGN_WORDS));
    expect_true(data_cnt >= en_cycles + TAIL_WORDS,
                $sformatf("frame holds %0d data words for %0d enabled cycles", data_cnt, en_cycles));
    if (len >= 2) begin
      expect_equal("capture_data_o[31:0] trailer", 64'(frame_q[len-1][31:0]),
                   64'(frame_q[0][31:0] + 32'(data_cnt)));
    end
  endtask

  // word s carries phase 0, the first upper I of 1 follows it
  task automatic check_chirp(input int len, input logic quadratic);
    int s;
    int k;
    int d;
    int i0;
    s = -1;
    for (k = 1; k < frame_q.size() - 1; k++) begin
      if (s < 0 && frame_q[k][63:48] == 16'h0001) begin
        s = k - 1;
      end
    end
    expect_true(s >= 1 && s + len < frame_q.size() - 1, "chirp samples do not fit in the frame");
    if (s >= 1 && s + len < frame_q.size() - 1) begin
      for (k = 0; k < len; k++) begin
        i0 = int'(frame_q[s+k][63:48]);
        // q is a quarter turn ahead of i
        expect_equal($sformatf("capture_data_o[47:32] word %0d", s + k),
                     64'(frame_q[s+k][47:32]), 64'(16'(i0 + int'(QUARTER_TURN[31:16]))));
        if (!quadratic && k >= 1) begin
          d = i0 - int'(frame_q[s+k-1][63:48]);
          expect_equal($sformatf("capture_data_o[63:48] step, word %0d", s + k), 64'(d), 64'(1));
        end
        if (quadratic && k >= 2) begin
          d = i0 - 2 * int'(frame_q[s+k-1][63:48]) + int'(frame_q[s+k-2][63:48]);
          expect_equal($sformatf("capture_data_o[63:48] 2nd diff, word %0d", s + k),
                       64'(d), 64'(1));
        end
      end
      // back to zero once the dds leaves run
      expect_equal("capture_data_o[63:48] after chirp", 64'(frame_q[s+len][63:48]), 64'(0));
    end
  endtask

  // data word k sits at frame index k + 1
  task automatic check_loopback();
    int k;
    capture_word_t up_w;
    capture_word_t lo_w;
    for (k = LOOPBACK_DELAY; k < frame_q.size() - 2; k++) begin
      up_w = frame_q[k + 1 - LOOPBACK_DELAY];
      lo_w = frame_q[k + 1];
      expect_equal($sformatf("capture_data_o[31:16] word %0d", k), 64'(lo_w[31:16]),
                   64'(halve_signed(up_w[63:48])));
      expect_equal($sformatf("capture_data_o[15:0] word %0d", k), 64'(lo_w[15:0]),
                   64'(halve_signed(up_w[47:32])));
    end
  endtask

  // both lanes on the sample counter, header lower lane is the start value
  task automatic check_counting();
    int k;
    for (k = 1; k < frame_q.size() - 1; k++) begin
      expect_equal($sformatf("capture_data_o[63:32] word %0d", k - 1),
                   64'(frame_q[k][63:32]), 64'(frame_q[k][31:0]));
      expect_equal($sformatf("capture_data_o[31:0] word %0d", k - 1),
                   64'(frame_q[k][31:0]), 64'(frame_q[0][31:0] + 32'(k - 1)));
    end
  endtask

  // capture window opens before init and closes after the loopback drains
  task automatic run_chirp(input logic [31:0] offset, input logic [31:0] coeff,
                           input int len, input logic [31:0] ctrl);
    int active_cnt;
    int en_cycles;
    int target;
    active_cnt = 0;
    en_cycles = 0;
    target = frame_cnt + 1;
    chirp_control_word_i = ctrl;
    chirp_freq_offset_i = offset;
    chirp_tuning_word_coeff_i = coeff;
    chirp_count_max_i = 32'(len);
    next_cycle();
    next_cycle();
    adc_enable_i = 1'b1;
    chirp_init_i = 1'b1;
    next_cycle();
    en_cycles++;
    chirp_init_i = 1'b0;
    chirp_enable_i = 1'b1;
    next_cycle();
    en_cycles++;
    chirp_enable_i = 1'b0;
    while (!chirp_done_o) begin
      if (chirp_active_o) begin
        active_cnt++;
      end
      next_cycle();
      en_cycles++;
    end
    expect_equal("chirp_active_o cycles", 64'(active_cnt), 64'(len));
    repeat (LOOPBACK_DELAY + 4) begin
      next_cycle();
      en_cycles++;
    end
    adc_enable_i = 1'b0;
    wait_frames(target);
    check_frame(en_cycles);
  endtask

  task automatic run_capture(input logic [31:0] ctrl, input int en_len);
    int target;
    target = frame_cnt + 1;
    chirp_control_word_i = ctrl;
    next_cycle();
    next_cycle();
    adc_enable_i = 1'b1;
    repeat (en_len) begin
      next_cycle();
    end
    adc_enable_i = 1'b0;
    wait_frames(target);
    check_frame(en_len);
  endtask

  task automatic finish_test(input string name, input int start_errs);
    if (total_errors() == start_errs) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, total_errors() - start_errs);
    end
  endtask

  initial begin
    int t0;
    void'($urandom(55));
    cpu_reset = 1'b1;
    chirp_init_i = 1'b0;
    chirp_enable_i = 1'b0;
    adc_enable_i = 1'b0;
    chirp_control_word_i = '0;
    chirp_freq_offset_i = '0;
    chirp_tuning_word_coeff_i = '0;
    chirp_count_max_i = '0;
    capture_ready_i = 1'b1;
    random_ready = 1'b0;
    next_cycle();
    next_cycle();
    cpu_reset = 1'b0;

    t0 = total_errors();
    expect_equal("capture_valid_o", 64'(capture_valid_o), 64'(0));
    expect_equal("chirp_active_o", 64'(chirp_active_o), 64'(0));
    expect_equal("chirp_done_o", 64'(chirp_done_o), 64'(0));
    expect_equal("capture_overflow_o", 64'(capture_overflow_o), 64'(0));
    expect_equal("chirp_ready_o", 64'(chirp_ready_o), 64'(1));
    finish_test("reset state", t0);

    // upper lane dds, lower lane adc
    t0 = total_errors();
    run_chirp(32'h0001_0000, 32'h0000_0000, 40, 32'h0000_0010);
    check_chirp(40, 1'b0);
    run_chirp(32'h0001_0000, 32'h0001_0000, 40, 32'h0000_0010);
    check_chirp(40, 1'b1);
    finish_test("chirp control", t0);

    // steep chirp so i and q wrap negative
    t0 = total_errors();
    run_chirp(32'h0800_0000, 32'h0000_4000, 40, 32'h0000_0010);
    check_loopback();
    finish_test("loopback", t0);

    // upper lane global counter, lower lane sample counter
    t0 = total_errors();
    run_capture(32'h0000_0032, 13);
    run_capture(32'h0000_0032, 5);
    finish_test("framing", t0);

    t0 = total_errors();
    random_ready = 1'b1;
    run_capture(32'h0000_0022, 10);
    check_counting();
    random_ready = 1'b0;
    expect_equal("capture_overflow_o", 64'(capture_overflow_o), 64'(0));
    // output held off for more words than the fifo holds
    capture_ready_i = 1'b0;
    adc_enable_i = 1'b1;
    repeat (FIFO_DEPTH + 4) begin
      next_cycle();
    end
    adc_enable_i = 1'b0;
    next_cycle();
    expect_equal("capture_overflow_o", 64'(capture_overflow_o), 64'(1));
    expect_equal("capture_valid_o", 64'(capture_valid_o), 64'(1));
    finish_test("back-pressure", t0);

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/chirp_pkg.sv
source/capture_if.sv
source/radar_ctrl_regs.sv
source/chirp_dds.sv
source/adc_loopback.sv
source/capture_framer.sv
source/capture_fifo.sv
source/radar_capture_top.sv
dv/radar_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the radar capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
  -f filelist.f --top-module radar_capture_tb \
  -Mdir obj_dir -o radar_capture_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/radar_capture_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* source/adc_loopback.sv */
`timescale 1ns/1ps

module adc_loopback (
  input  logic                  clk_245_76MHz,
  input  logic                  cpu_reset,
  input  chirp_pkg::iq_sample_t dds_i_i,
  input  chirp_pkg::iq_sample_t dds_q_i,
  output chirp_pkg::iq_pair_t   dac_pair_o,
  output chirp_pkg::iq_pair_t   adc_pair_o
);
  import chirp_pkg::*;

  // register stages ahead of the dac
  iq_pair_t dac_pipe [DAC_STAGES];
  // adc return path, one entry per sample of delay
  iq_pair_t adc_dly [LOOPBACK_DELAY];
  iq_pair_t dac_half;

  assign dac_pair_o = dac_pipe[DAC_STAGES-1];

  // halve i and q separately, sign kept
  assign dac_half = {dac_pair_o[2*SAMPLE_W-1], dac_pair_o[2*SAMPLE_W-1:SAMPLE_W+1],
                     dac_pair_o[SAMPLE_W-1], dac_pair_o[SAMPLE_W-1:1]};

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int s = 0; s < DAC_STAGES; s++) begin
        dac_pipe[s] <= '0;
      end
      for (int d = 0; d < LOOPBACK_DELAY; d++) begin
        adc_dly[d] <= '0;
      end
    end else begin
      dac_pipe[0] <= {dds_i_i, dds_q_i};
      for (int s = 1; s < DAC_STAGES; s++) begin
        dac_pipe[s] <= dac_pipe[s-1];
      end
      // adc at cycle t is the halved dac from t - LOOPBACK_DELAY
      adc_dly[0] <= dac_half;
      for (int d = 1; d < LOOPBACK_DELAY; d++) begin
        adc_dly[d] <= adc_dly[d-1];
      end
    end
  end

  assign adc_pair_o = adc_dly[LOOPBACK_DELAY-1];

endmodule

/* source/capture_fifo.sv */
`timescale 1ns/1ps

module capture_fifo (
  input  logic                     clk_245_76MHz,
  input  logic                     cpu_reset,
  capture_if.fifo                  in_if,
  input  logic                     capture_ready_i,
  output chirp_pkg::capture_word_t capture_data_o,
  output logic                     capture_valid_o,
  output logic                     capture_first_o,
  output logic                     capture_last_o,
  output logic                     capture_overflow_o
);
  import chirp_pkg::*;

  // word storage with its frame flags
  capture_word_t mem_word [FIFO_DEPTH];
  logic mem_first [FIFO_DEPTH];
  logic mem_last [FIFO_DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  logic [FIFO_ADDR_W:0] fill;
  logic full;
  logic push;
  logic pop;

  assign full = (fill == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
  // no room means the word is lost
  assign push = in_if.valid && !full;
  assign pop = capture_valid_o && capture_ready_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem_word[wr_ptr] <= in_if.word;
      mem_first[wr_ptr] <= in_if.first;
      mem_last[wr_ptr] <= in_if.last;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      capture_overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + FIFO_ADDR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + FIFO_ADDR_W'(1);
      end
      if (push && !pop) begin
        fill <= fill + (FIFO_ADDR_W+1)'(1);
      end else if (pop && !push) begin
        fill <= fill - (FIFO_ADDR_W+1)'(1);
      end
      // sticky until reset
      if (in_if.valid && full) begin
        capture_overflow_o <= 1'b1;
      end
    end
  end

  // head entry shown straight from the buffer
  assign capture_valid_o = (fill != '0);
  assign capture_data_o = mem_word[rd_ptr];
  assign capture_first_o = capture_valid_o && mem_first[rd_ptr];
  assign capture_last_o = capture_valid_o && mem_last[rd_ptr];

  a_hold_on_stall: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    capture_valid_o && !capture_ready_i |=> capture_valid_o && $stable(capture_data_o)
      && $stable(capture_first_o) && $stable(capture_last_o));

endmodule

/* source/capture_framer.sv */
`timescale 1ns/1ps

module capture_framer (
  input  logic                   clk_245_76MHz,
  input  logic                   cpu_reset,
  input  logic                   capture_enable_i,
  input  chirp_pkg::lane_route_e route_lower_i,
  input  chirp_pkg::lane_route_e route_upper_i,
  input  chirp_pkg::iq_pair_t    dac_pair_i,
  input  chirp_pkg::iq_pair_t    adc_pair_i,
  output logic                   capture_busy_o,
  capture_if.framer              out_if
);
  import chirp_pkg::*;

  // header goes out on leaving idle, trailer on leaving pad
  typedef enum logic [1:0] {
    FR_IDLE,
    FR_BODY,
    FR_TAIL,
    FR_PAD
  } frame_state_e;

  frame_state_e state;
  frame_state_e state_next;
  count_t global_cnt;
  // advances once per data word, never cleared between frames
  count_t sample_cnt;
  logic [TAIL_CNT_W-1:0] tail_cnt;
  // words of the frame so far, header included, modulo the granule
  logic [ALIGN_CNT_W-1:0] word_cnt;
  logic emit_hdr;
  logic emit_data;
  logic emit_trl;
  logic tail_load;
  lane_word_t lane_upper;
  lane_word_t lane_lower;

  // pick one of the four lane sources
  function automatic lane_word_t route_lane(input lane_route_e sel, input iq_pair_t adc,
                                            input iq_pair_t dac, input count_t smp,
                                            input count_t glb);
    lane_word_t lane;
    case (sel)
      ROUTE_ADC: lane = adc;
      ROUTE_DAC: lane = dac;
      ROUTE_SAMPLE_CNT: lane = smp;
      default: lane = glb;
    endcase
    return lane;
  endfunction

  assign lane_upper = route_lane(route_upper_i, adc_pair_i, dac_pair_i, sample_cnt, global_cnt);
  assign lane_lower = route_lane(route_lower_i, adc_pair_i, dac_pair_i, sample_cnt, global_cnt);

  always_comb begin
    state_next = state;
    emit_hdr = 1'b0;
    emit_data = 1'b0;
    emit_trl = 1'b0;
    tail_load = 1'b0;
    case (state)
      FR_IDLE: begin
        if (capture_enable_i) begin
          emit_hdr = 1'b1;
          state_next = FR_BODY;
        end
      end
      FR_BODY: begin
        emit_data = 1'b1;
        // enable gone, still owe TAIL_WORDS words for dds latency
        if (!capture_enable_i) begin
          tail_load = 1'b1;
          state_next = FR_TAIL;
        end
      end
      FR_TAIL: begin
        emit_data = 1'b1;
        if (tail_cnt == TAIL_CNT_W'(1)) begin
          state_next = FR_PAD;
        end
      end
      FR_PAD: begin
        // trailer once it closes the frame on the granule
        if (word_cnt == ALIGN_CNT_W'(FRAME_ALIGN_WORDS - 1)) begin
          emit_trl = 1'b1;
          state_next = FR_IDLE;
        end else begin
          emit_data = 1'b1;
        end
      end
      default: begin
        state_next = FR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state <= FR_IDLE;
      global_cnt <= '0;
      sample_cnt <= '0;
      tail_cnt <= '0;
      word_cnt <= '0;
      out_if.word <= '0;
      out_if.valid <= 1'b0;
      out_if.first <= 1'b0;
      out_if.last <= 1'b0;
    end else begin
      state <= state_next;
      global_cnt <= global_cnt + count_t'(1);
      if (tail_load) begin
        tail_cnt <= TAIL_CNT_W'(TAIL_WORDS);
      end else if (state == FR_TAIL) begin
        tail_cnt <= tail_cnt - TAIL_CNT_W'(1);
      end
      if (emit_hdr) begin
        word_cnt <= ALIGN_CNT_W'(1);
      end else if (emit_data) begin
        word_cnt <= word_cnt + ALIGN_CNT_W'(1);
        sample_cnt <= sample_cnt + count_t'(1);
      end
      // header and trailer share one layout
      if (emit_data) begin
        out_if.word <= {lane_upper, lane_lower};
      end else if (emit_hdr || emit_trl) begin
        out_if.word <= {global_cnt, sample_cnt};
      end
      out_if.valid <= emit_hdr || emit_data || emit_trl;
      out_if.first <= emit_hdr;
      out_if.last <= emit_trl;
    end
  end

  assign capture_busy_o = (state != FR_IDLE);

  a_first_last_apart: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    out_if.valid |-> !(out_if.first && out_if.last));

endmodule

/* source/capture_if.sv */
`timescale 1ns/1ps

// framed words from the framer into the output fifo
interface capture_if;
  import chirp_pkg::*;

  // {upper lane, lower lane} or a header/trailer word
  capture_word_t word;
  // one word per cycle while high
  logic valid;
  // header word of a frame
  logic first;
  // trailer word of a frame
  logic last;

  // framer cannot stall, so no ready back
  modport framer (
    output word,
    output valid,
    output first,
    output last
  );

  modport fifo (
    input word,
    input valid,
    input first,
    input last
  );

endinterface

/* source/chirp_dds.sv */
`timescale 1ns/1ps

module chirp_dds (
  input  logic                  clk_245_76MHz,
  input  logic                  cpu_reset,
  input  logic                  chirp_init_i,
  input  logic                  chirp_enable_i,
  input  chirp_pkg::phase_t     freq_offset_i,
  input  chirp_pkg::phase_t     tuning_coeff_i,
  input  chirp_pkg::count_t     chirp_len_i,
  output logic                  chirp_ready_o,
  output logic                  chirp_active_o,
  output logic                  chirp_done_o,
  output chirp_pkg::iq_sample_t dds_i_o,
  output chirp_pkg::iq_sample_t dds_q_o
);
  import chirp_pkg::*;

  dds_state_e state;
  // quadratic phase: phase += freq, freq += coeff
  phase_t phase;
  phase_t freq;
  phase_t phase_q;
  // active cycles so far in this chirp
  count_t run_cnt;
  logic done_q;
  logic last_run;

  assign last_run = (run_cnt == chirp_len_i - count_t'(1));

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state <= DDS_IDLE;
      phase <= '0;
      freq <= '0;
      run_cnt <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        DDS_IDLE: begin
          if (chirp_init_i) begin
            state <= DDS_ARMED;
          end
        end
        DDS_ARMED: begin
          // accumulators start fresh on the first active cycle
          if (chirp_enable_i) begin
            state <= DDS_RUN;
            phase <= '0;
            freq <= freq_offset_i;
            run_cnt <= '0;
          end
        end
        DDS_RUN: begin
          phase <= phase + freq;
          freq <= freq + tuning_coeff_i;
          run_cnt <= run_cnt + count_t'(1);
          // done lands on the cycle after the last active one
          if (last_run) begin
            state <= DDS_IDLE;
            done_q <= 1'b1;
          end
        end
        default: begin
          state <= DDS_IDLE;
        end
      endcase
    end
  end

  // q leads i by a quarter turn
  assign phase_q = phase + QUARTER_TURN;

  // sawtooth outputs, zero when not running
  assign dds_i_o = (state == DDS_RUN) ? phase[PHASE_W-1 -: SAMPLE_W] : '0;
  assign dds_q_o = (state == DDS_RUN) ? phase_q[PHASE_W-1 -: SAMPLE_W] : '0;

  assign chirp_ready_o = (state == DDS_IDLE);
  assign chirp_active_o = (state == DDS_RUN);
  assign chirp_done_o = done_q;

  a_done_pulse: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    chirp_done_o |=> !chirp_done_o);

  a_active_not_ready: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(chirp_active_o && chirp_ready_o));

endmodule

/* source/chirp_pkg.sv */
package chirp_pkg;

  // sample, accumulator and counter widths
  localparam int SAMPLE_W = 16;
  localparam int PHASE_W = 32;
  localparam int COUNT_W = 32;
  localparam int LANE_W = 2 * SAMPLE_W;

  typedef logic [SAMPLE_W-1:0] iq_sample_t;
  // i in the upper half, q in the lower half
  typedef logic [2*SAMPLE_W-1:0] iq_pair_t;
  typedef logic [LANE_W-1:0] lane_word_t;
  // upper lane, lower lane
  typedef logic [2*LANE_W-1:0] capture_word_t;
  typedef logic [PHASE_W-1:0] phase_t;
  typedef logic [COUNT_W-1:0] count_t;

  // lane source select, same encoding as the control word fields
  typedef enum logic [1:0] {
    ROUTE_ADC        = 2'd0,
    ROUTE_DAC        = 2'd1,
    ROUTE_SAMPLE_CNT = 2'd2,
    ROUTE_GLOBAL_CNT = 2'd3
  } lane_route_e;

  typedef enum logic [1:0] {
    DDS_IDLE,
    DDS_ARMED,
    DDS_RUN
  } dds_state_e;

  localparam int DAC_STAGES = 2;
  localparam int LOOPBACK_DELAY = 16;
  localparam int TAIL_WORDS = 3;
  localparam int FRAME_ALIGN_WORDS = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int ROUTE_LOWER_LSB = 0;
  localparam int ROUTE_UPPER_LSB = 4;
  localparam phase_t QUARTER_TURN = 32'h4000_0000;

  // derived counter widths
  localparam int TAIL_CNT_W = $clog2(TAIL_WORDS + 1);
  localparam int ALIGN_CNT_W = $clog2(FRAME_ALIGN_WORDS);
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

endpackage

/* source/radar_capture_top.sv */
`timescale 1ns/1ps

module radar_capture_top (
  input  logic        clk_245_76MHz,
  input  logic        cpu_reset,
  input  logic        chirp_init_i,
  input  logic        chirp_enable_i,
  input  logic        adc_enable_i,
  input  logic [31:0] chirp_control_word_i,
  input  logic [31:0] chirp_freq_offset_i,
  input  logic [31:0] chirp_tuning_word_coeff_i,
  input  logic [31:0] chirp_count_max_i,
  input  logic        capture_ready_i,
  output logic        chirp_ready_o,
  output logic        chirp_active_o,
  output logic        chirp_done_o,
  output logic [63:0] capture_data_o,
  output logic        capture_valid_o,
  output logic        capture_first_o,
  output logic        capture_last_o,
  output logic        capture_overflow_o
);
  import chirp_pkg::*;

  // latched chirp params
  phase_t freq_offset;
  phase_t tuning_coeff;
  count_t chirp_len;
  // lane routing, frozen per frame
  lane_route_e route_lower;
  lane_route_e route_upper;
  logic capture_enable;
  logic capture_busy;
  iq_sample_t dds_i;
  iq_sample_t dds_q;
  iq_pair_t dac_pair;
  iq_pair_t adc_pair;

  // framer to fifo
  capture_if cap_if ();

  radar_ctrl_regs radar_ctrl_regs_i (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset(cpu_reset),
    .chirp_init_i(chirp_init_i),
    .adc_enable_i(adc_enable_i),
    .chirp_control_word_i(chirp_control_word_i),
    .chirp_freq_offset_i(chirp_freq_offset_i),
    .chirp_tuning_word_coeff_i(chirp_tuning_word_coeff_i),
    .chirp_count_max_i(chirp_count_max_i),
    .dds_ready_i(chirp_ready_o),
    .capture_busy_i(capture_busy),
    .freq_offset_o(freq_offset),
    .tuning_coeff_o(tuning_coeff),
    .chirp_len_o(chirp_len),
    .route_lower_o(route_lower),
    .route_upper_o(route_upper),
    .capture_enable_o(capture_enable)
  );

  chirp_dds chirp_dds_i (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset(cpu_reset),
    .chirp_init_i(chirp_init_i),
    .chirp_enable_i(chirp_enable_i),
    .freq_offset_i(freq_offset),
    .tuning_coeff_i(tuning_coeff),
    .chirp_len_i(chirp_len),
    .chirp_ready_o(chirp_ready_o),
    .chirp_active_o(chirp_active_o),
    .chirp_done_o(chirp_done_o),
    .dds_i_o(dds_i),
    .dds_q_o(dds_q)
  );

  adc_loopback adc_loopback_i (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset(cpu_reset),
    .dds_i_i(dds_i),
    .dds_q_i(dds_q),
    .dac_pair_o(dac_pair),
    .adc_pair_o(adc_pair)
  );

  capture_framer capture_framer_i (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset(cpu_reset),
    .capture_enable_i(capture_enable),
    .route_lower_i(route_lower),
    .route_upper_i(route_upper),
    .dac_pair_i(dac_pair),
    .adc_pair_i(adc_pair),
    .capture_busy_o(capture_busy),
    .out_if(cap_if.framer)
  );

  capture_fifo capture_fifo_i (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset(cpu_reset),
    .in_if(cap_if.fifo),
    .capture_ready_i(capture_ready_i),
    .capture_data_o(capture_data_o),
    .capture_valid_o(capture_valid_o),
    .capture_first_o(capture_first_o),
    .capture_last_o(capture_last_o),
    .capture_overflow_o(capture_overflow_o)
  );

endmodule

/* source/radar_ctrl_regs.sv */
`timescale 1ns/1ps

module radar_ctrl_regs (
  input  logic                  clk_245_76MHz,
  input  logic                  cpu_reset,
  input  logic                  chirp_init_i,
  input  logic                  adc_enable_i,
  input  logic [31:0]           chirp_control_word_i,
  input  chirp_pkg::phase_t     chirp_freq_offset_i,
  input  chirp_pkg::phase_t     chirp_tuning_word_coeff_i,
  input  chirp_pkg::count_t     chirp_count_max_i,
  input  logic                  dds_ready_i,
  input  logic                  capture_busy_i,
  output chirp_pkg::phase_t     freq_offset_o,
  output chirp_pkg::phase_t     tuning_coeff_o,
  output chirp_pkg::count_t     chirp_len_o,
  output chirp_pkg::lane_route_e route_lower_o,
  output chirp_pkg::lane_route_e route_upper_o,
  output logic                  capture_enable_o
);
  import chirp_pkg::*;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      freq_offset_o <= '0;
      tuning_coeff_o <= '0;
      chirp_len_o <= '0;
      route_lower_o <= ROUTE_ADC;
      route_upper_o <= ROUTE_ADC;
      capture_enable_o <= 1'b0;
    end else begin
      // chirp params only taken while the dds is ready
      // init during a running chirp is ignored here
      if (chirp_init_i && dds_ready_i) begin
        freq_offset_o <= chirp_freq_offset_i;
        tuning_coeff_o <= chirp_tuning_word_coeff_i;
        chirp_len_o <= chirp_count_max_i;
      end
      // routes track the control word between frames, frozen inside one
      if (!capture_busy_i) begin
        route_lower_o <= lane_route_e'(chirp_control_word_i[ROUTE_LOWER_LSB +: 2]);
        route_upper_o <= lane_route_e'(chirp_control_word_i[ROUTE_UPPER_LSB +: 2]);
      end
      // single register stage on the capture enable
      capture_enable_o <= adc_enable_i;
    end
  end

  // a frame must see one route setting from header to trailer
  a_route_frozen: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    $past(capture_busy_i) |-> $stable(route_lower_o) && $stable(route_upper_o));

endmodule
